//--- logic/wb_pkg.sv
package wb_pkg;

   // widths
   localparam int ctrl_w  = 16;
   localparam int flags_w = 32;

   // writeback control word bit positions
   // port 1 gets the return address
   localparam int cs_save_neip     = 0;
   localparam int cs_push_flags    = 1;
   // two-uop string compare
   localparam int cs_cmps_first    = 2;
   localparam int cs_cmps_second   = 3;
   // far transfers take eip/cs from the temp register
   localparam int cs_use_temp_neip = 4;
   localparam int cs_use_temp_ncs  = 5;
   localparam int cs_ld_eip        = 6;
   // conditional qualifiers
   localparam int cs_is_jne        = 7;
   localparam int cs_is_jnbe       = 8;
   localparam int cs_is_cmovc      = 9;
   localparam int cs_ld_gpr3       = 10;
   localparam int cs_ld_seg        = 11;
   localparam int cs_ld_cs         = 12;
   localparam int cs_ld_flags      = 13;
   localparam int cs_pop_flags     = 14;
   // bit 15 spare

   // eflags bit positions
   localparam int flag_cf   = 0;
   localparam int flag_rsv1 = 1;
   localparam int flag_zf   = 6;

   // cf pf af zf sf of
   localparam logic [flags_w-1:0] flags_affected_mask = 32'h0000_08d5;

   // reserved bit 1 set, everything else clear
   localparam logic [flags_w-1:0] flags_reset = 32'h0000_0002;

endpackage

//--- logic/wb_flags_reg.sv
`timescale 1ns/1ps

module wb_flags_reg (
   input  logic                       CLK,
   input  logic                       rst_n,
   input  logic                       ld,
   input  logic                       pop,
   input  logic [wb_pkg::flags_w-1:0] new_flags,
   input  logic [wb_pkg::flags_w-1:0] pop_value,
   input  logic                       hold,
   output logic [wb_pkg::flags_w-1:0] flags
);

   logic [wb_pkg::flags_w-1:0] flags_q;
   logic [wb_pkg::flags_w-1:0] flags_d;
   logic [wb_pkg::flags_w-1:0] merged;
   logic                       update;

   // only the arithmetic bits come from the alu
   assign merged = (flags_q & ~wb_pkg::flags_affected_mask)
                 | (new_flags & wb_pkg::flags_affected_mask);

   // popf replaces the whole register
   always_comb begin
      if (pop) begin
         flags_d = pop_value;
      end else begin
         flags_d = merged;
      end
   end

   // no update while the stage is stalled
   assign update = ld & ~hold;

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         flags_q <= wb_pkg::flags_reset;
      end else if (update) begin
         flags_q <= flags_d;
      end
   end

   // bit 1 is reserved and reads as one
   always_comb begin
      flags                    = flags_q;
      flags[wb_pkg::flag_rsv1] = 1'b1;
   end

endmodule

//--- logic/wb_branch_cond.sv
`timescale 1ns/1ps

module wb_branch_cond (
   input  logic [wb_pkg::ctrl_w-1:0]  ctrl,
   input  logic [wb_pkg::flags_w-1:0] flags,
   input  logic                       ex_ld_gpr2,
   output logic                       ld_eip,
   output logic                       ld_gpr2
);

   logic cf;
   logic zf;
   logic cond_ok;

   assign cf = flags[wb_pkg::flag_cf];
   assign zf = flags[wb_pkg::flag_zf];

   // branch condition, taken when no condition is selected
   always_comb begin
      if (ctrl[wb_pkg::cs_is_jne]) begin
         cond_ok = ~zf;
      end else if (ctrl[wb_pkg::cs_is_jnbe]) begin
         cond_ok = ~cf & ~zf;
      end else begin
         cond_ok = 1'b1;
      end
   end

   assign ld_eip = ctrl[wb_pkg::cs_ld_eip] & cond_ok;

   // cmovc only writes the destination when carry is set
   always_comb begin
      if (ctrl[wb_pkg::cs_is_cmovc]) begin
         ld_gpr2 = ex_ld_gpr2 & cf;
      end else begin
         ld_gpr2 = ex_ld_gpr2;
      end
   end

endmodule

//--- logic/wb_commit_gate.sv
`timescale 1ns/1ps

module wb_commit_gate (
   input  logic                       valid,
   input  logic [wb_pkg::ctrl_w-1:0]  ctrl,
   input  logic                       ex_ld_gpr1,
   input  logic                       ld_gpr2,
   input  logic                       ld_eip,
   input  logic                       ex_dcache_write,
   input  logic                       repne,
   input  logic [wb_pkg::flags_w-1:0] flags,
   input  logic                       write_ready,
   output logic                       v_ld_gpr1,
   output logic                       v_ld_gpr2,
   output logic                       v_ld_gpr3,
   output logic                       v_ld_seg,
   output logic                       v_ld_cs,
   output logic                       v_ld_flags,
   output logic                       v_ld_eip,
   output logic                       v_dcache_write,
   output logic                       repne_terminate,
   output logic                       stall
);

   logic zf;

   assign zf = flags[wb_pkg::flag_zf];

   // enables from decode/execute
   assign v_ld_gpr1      = valid & ex_ld_gpr1;
   assign v_ld_gpr2      = valid & ld_gpr2;
   assign v_dcache_write = valid & ex_dcache_write;

   // enables straight from the control word
   assign v_ld_gpr3  = valid & ctrl[wb_pkg::cs_ld_gpr3];
   assign v_ld_seg   = valid & ctrl[wb_pkg::cs_ld_seg];
   assign v_ld_cs    = valid & ctrl[wb_pkg::cs_ld_cs];
   assign v_ld_flags = valid & ctrl[wb_pkg::cs_ld_flags];

   // already qualified by the branch condition
   assign v_ld_eip = valid & ld_eip;

   // repne scas/cmps ends on the second uop once zf is set
   always_comb begin
      repne_terminate = 1'b0;
      if (valid && repne && ctrl[wb_pkg::cs_cmps_second]) begin
         repne_terminate = zf;
      end
   end

   // dcache write port busy, hold the pipe
   assign stall = v_dcache_write & ~write_ready;

endmodule

//--- logic/wb_operand_select.sv
`timescale 1ns/1ps

module wb_operand_select (
   input  logic                       CLK,
   input  logic                       rst_n,
   input  logic                       valid,
   input  logic                       hold,
   input  logic [wb_pkg::ctrl_w-1:0]  ctrl,
   input  logic [31:0]                result_a,
   input  logic [31:0]                neip,
   input  logic [15:0]                ncs,
   input  logic [wb_pkg::flags_w-1:0] flags,
   output logic [31:0]                data1,
   output logic [31:0]                eip,
   output logic [15:0]                cs,
   output logic [31:0]                count
);

   logic [31:0] temp_q;
   logic        capture;

   // first compare uop parks result a here for the second uop
   assign capture = valid & ctrl[wb_pkg::cs_cmps_first] & ~hold;

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         temp_q <= '0;
      end else if (capture) begin
         temp_q <= result_a;
      end
   end

   assign count = temp_q;

   // port 1 source, fixed priority
   always_comb begin
      if (ctrl[wb_pkg::cs_save_neip]) begin
         data1 = neip;
      end else if (ctrl[wb_pkg::cs_push_flags]) begin
         data1 = flags;
      end else if (ctrl[wb_pkg::cs_cmps_second]) begin
         data1 = temp_q;
      end else begin
         data1 = result_a;
      end
   end

   // far jump/call/ret target
   always_comb begin
      if (ctrl[wb_pkg::cs_use_temp_neip]) begin
         eip = temp_q;
      end else begin
         eip = neip;
      end
   end

   always_comb begin
      if (ctrl[wb_pkg::cs_use_temp_ncs]) begin
         cs = temp_q[15:0];
      end else begin
         cs = ncs;
      end
   end

endmodule

//--- logic/writeback.sv
`timescale 1ns/1ps

module writeback (
   input  logic                       CLK,
   input  logic                       rst_n,

   input  logic                       WB_V,
   input  logic [31:0]                WB_NEIP,
   input  logic [15:0]                WB_NCS,
   input  logic [wb_pkg::ctrl_w-1:0]  wb_ctrl,
   // generated in decode, not part of the control word
   input  logic [1:0]                 WB_d2_datasize_all,
   input  logic                       WB_ex_ld_gpr1_wb,
   input  logic                       WB_ex_ld_gpr2_wb,
   input  logic                       WB_ex_dcache_write_wb,
   input  logic                       WB_d2_repne_wb,

   input  logic [31:0]                WB_RESULT_A,
   input  logic [31:0]                WB_RESULT_B,
   input  logic [31:0]                WB_RESULT_C,
   input  logic [wb_pkg::flags_w-1:0] WB_FLAGS,

   input  logic [2:0]                 WB_DR1,
   input  logic [2:0]                 WB_DR2,
   input  logic [2:0]                 WB_DR3,
   input  logic [31:0]                WB_ADDRESS,

   input  logic                       In_write_ready,

   output logic [2:0]                 WB_Final_DR1,
   output logic [2:0]                 WB_Final_DR2,
   output logic [2:0]                 WB_Final_DR3,
   output logic [31:0]                WB_Final_data1,
   output logic [31:0]                WB_Final_data2,
   output logic [31:0]                WB_Final_data3,
   output logic                       WB_Final_ld_gpr1,
   output logic                       WB_Final_ld_gpr2,
   output logic                       WB_Final_ld_gpr3,
   output logic [1:0]                 WB_Final_datasize,
   output logic                       WB_Final_ld_seg,
   output logic [31:0]                WB_Final_EIP,
   output logic                       WB_Final_ld_eip,
   output logic [15:0]                WB_Final_CS,
   output logic                       WB_Final_ld_cs,
   output logic [wb_pkg::flags_w-1:0] WB_Final_Flags,
   output logic                       WB_Final_ld_flags,
   output logic [63:0]                WB_Final_Dcache_Data,
   output logic [31:0]                WB_Final_Dcache_address,

   output logic                       DEP_v_wb_ld_gpr1,
   output logic                       DEP_v_wb_ld_gpr2,
   output logic                       DEP_v_wb_ld_gpr3,
   output logic                       DEP_v_wb_ld_seg,
   output logic                       DEP_v_wb_dcache_write,

   output logic                       wb_repne_terminate_all,
   output logic                       WB_stall,

   output logic [wb_pkg::flags_w-1:0] flags_dataforwarded,
   output logic [31:0]                count_dataforwarded
);

   logic                       stage_valid;
   logic [wb_pkg::flags_w-1:0] current_flags;
   logic                       wb_ld_eip;
   logic                       wb_ld_gpr2;
   logic                       v_ld_gpr1;
   logic                       v_ld_gpr2;
   logic                       v_ld_gpr3;
   logic                       v_ld_seg;
   logic                       v_ld_cs;
   logic                       v_ld_flags;
   logic                       v_ld_eip;
   logic                       v_dcache_write;
   logic [31:0]                data1;
   logic [31:0]                count;

   // nothing commits while reset is asserted
   assign stage_valid = WB_V & rst_n;

   wb_flags_reg u_flags_reg (
      .CLK       (CLK),
      .rst_n     (rst_n),
      .ld        (v_ld_flags),
      .pop       (wb_ctrl[wb_pkg::cs_pop_flags]),
      .new_flags (WB_FLAGS),
      .pop_value (WB_RESULT_A),
      .hold      (WB_stall),
      .flags     (current_flags)
   );

   wb_branch_cond u_branch_cond (
      .ctrl       (wb_ctrl),
      .flags      (current_flags),
      .ex_ld_gpr2 (WB_ex_ld_gpr2_wb),
      .ld_eip     (wb_ld_eip),
      .ld_gpr2    (wb_ld_gpr2)
   );

   wb_commit_gate u_commit_gate (
      .valid           (stage_valid),
      .ctrl            (wb_ctrl),
      .ex_ld_gpr1      (WB_ex_ld_gpr1_wb),
      .ld_gpr2         (wb_ld_gpr2),
      .ld_eip          (wb_ld_eip),
      .ex_dcache_write (WB_ex_dcache_write_wb),
      .repne           (WB_d2_repne_wb),
      .flags           (current_flags),
      .write_ready     (In_write_ready),
      .v_ld_gpr1       (v_ld_gpr1),
      .v_ld_gpr2       (v_ld_gpr2),
      .v_ld_gpr3       (v_ld_gpr3),
      .v_ld_seg        (v_ld_seg),
      .v_ld_cs         (v_ld_cs),
      .v_ld_flags      (v_ld_flags),
      .v_ld_eip        (v_ld_eip),
      .v_dcache_write  (v_dcache_write),
      .repne_terminate (wb_repne_terminate_all),
      .stall           (WB_stall)
   );

   wb_operand_select u_operand_select (
      .CLK      (CLK),
      .rst_n    (rst_n),
      .valid    (stage_valid),
      .hold     (WB_stall),
      .ctrl     (wb_ctrl),
      .result_a (WB_RESULT_A),
      .neip     (WB_NEIP),
      .ncs      (WB_NCS),
      .flags    (current_flags),
      .data1    (data1),
      .eip      (WB_Final_EIP),
      .cs       (WB_Final_CS),
      .count    (count)
   );

   // register file
   assign WB_Final_DR1      = WB_DR1;
   assign WB_Final_DR2      = WB_DR2;
   assign WB_Final_DR3      = WB_DR3;
   assign WB_Final_data1    = data1;
   assign WB_Final_data2    = WB_RESULT_B;
   assign WB_Final_data3    = WB_RESULT_C;
   assign WB_Final_ld_gpr1  = v_ld_gpr1;
   assign WB_Final_ld_gpr2  = v_ld_gpr2;
   assign WB_Final_ld_gpr3  = v_ld_gpr3;
   assign WB_Final_datasize = WB_d2_datasize_all;

   // segment, eip, cs and flags
   assign WB_Final_ld_seg   = v_ld_seg;
   assign WB_Final_ld_eip   = v_ld_eip;
   assign WB_Final_ld_cs    = v_ld_cs;
   assign WB_Final_Flags    = current_flags;
   assign WB_Final_ld_flags = v_ld_flags;

   // dcache data port is 64 bits wide
   assign WB_Final_Dcache_Data    = {32'b0, data1};
   assign WB_Final_Dcache_address = WB_ADDRESS;

   // dependency check
   assign DEP_v_wb_ld_gpr1      = v_ld_gpr1;
   assign DEP_v_wb_ld_gpr2      = v_ld_gpr2;
   assign DEP_v_wb_ld_gpr3      = v_ld_gpr3;
   assign DEP_v_wb_ld_seg       = v_ld_seg;
   assign DEP_v_wb_dcache_write = v_dcache_write;

   // forwarding to execute
   assign flags_dataforwarded = current_flags;
   assign count_dataforwarded = count;

endmodule

//--- verif/writeback_assertions.sv
`timescale 1ns/1ps

module writeback_assertions (
   input logic                       CLK,
   input logic                       rst_n,
   input logic                       WB_V,
   input logic                       WB_Final_ld_gpr1,
   input logic                       WB_Final_ld_gpr2,
   input logic                       WB_Final_ld_gpr3,
   input logic                       WB_Final_ld_seg,
   input logic                       WB_Final_ld_eip,
   input logic                       WB_Final_ld_cs,
   input logic                       WB_Final_ld_flags,
   input logic                       DEP_v_wb_ld_gpr1,
   input logic                       DEP_v_wb_ld_gpr2,
   input logic                       DEP_v_wb_ld_gpr3,
   input logic                       DEP_v_wb_ld_seg,
   input logic                       DEP_v_wb_dcache_write,
   input logic                       WB_stall,
   input logic [wb_pkg::flags_w-1:0] WB_Final_Flags
);

   logic any_ld;

   assign any_ld = WB_Final_ld_gpr1 | WB_Final_ld_gpr2 | WB_Final_ld_gpr3
                 | WB_Final_ld_seg | WB_Final_ld_eip | WB_Final_ld_cs | WB_Final_ld_flags
                 | DEP_v_wb_ld_gpr1 | DEP_v_wb_ld_gpr2 | DEP_v_wb_ld_gpr3
                 | DEP_v_wb_ld_seg | DEP_v_wb_dcache_write;

   no_ld_when_invalid: assert property (@(posedge CLK) disable iff (!rst_n)
      !WB_V |-> !any_ld)
      else $error("commit enable high while WB_V is low");

   // stall only comes from a pending dcache write
   stall_needs_write: assert property (@(posedge CLK) disable iff (!rst_n)
      WB_stall |-> DEP_v_wb_dcache_write)
      else $error("WB_stall high without a dcache write");

   flags_hold_in_stall: assert property (@(posedge CLK) disable iff (!rst_n)
      WB_stall |=> $stable(WB_Final_Flags))
      else $error("flags changed across a stall cycle");

endmodule

bind writeback writeback_assertions u_assertions (.*);

//--- verif/writeback_tb.sv
`timescale 1ns/1ps

module writeback_tb;

   localparam int    max_vectors    = 64;
   localparam int    words_per_vec  = 12;
   localparam int    mem_depth      = 1 + max_vectors * words_per_vec;
   localparam int    timeout_cycles = 2000;
   localparam string pattern_file   = "verif/writeback_patterns.txt";

   logic                       CLK;
   logic                       rst_n;
   logic                       WB_V;
   logic [31:0]                WB_NEIP;
   logic [15:0]                WB_NCS;
   logic [wb_pkg::ctrl_w-1:0]  wb_ctrl;
   logic [1:0]                 WB_d2_datasize_all;
   logic                       WB_ex_ld_gpr1_wb;
   logic                       WB_ex_ld_gpr2_wb;
   logic                       WB_ex_dcache_write_wb;
   logic                       WB_d2_repne_wb;
   logic [31:0]                WB_RESULT_A;
   logic [31:0]                WB_RESULT_B;
   logic [31:0]                WB_RESULT_C;
   logic [wb_pkg::flags_w-1:0] WB_FLAGS;
   logic [2:0]                 WB_DR1;
   logic [2:0]                 WB_DR2;
   logic [2:0]                 WB_DR3;
   logic [31:0]                WB_ADDRESS;
   logic                       In_write_ready;
   logic [2:0]                 WB_Final_DR1;
   logic [2:0]                 WB_Final_DR2;
   logic [2:0]                 WB_Final_DR3;
   logic [31:0]                WB_Final_data1;
   logic [31:0]                WB_Final_data2;
   logic [31:0]                WB_Final_data3;
   logic                       WB_Final_ld_gpr1;
   logic                       WB_Final_ld_gpr2;
   logic                       WB_Final_ld_gpr3;
   logic [1:0]                 WB_Final_datasize;
   logic                       WB_Final_ld_seg;
   logic [31:0]                WB_Final_EIP;
   logic                       WB_Final_ld_eip;
   logic [15:0]                WB_Final_CS;
   logic                       WB_Final_ld_cs;
   logic [wb_pkg::flags_w-1:0] WB_Final_Flags;
   logic                       WB_Final_ld_flags;
   logic [63:0]                WB_Final_Dcache_Data;
   logic [31:0]                WB_Final_Dcache_address;
   logic                       DEP_v_wb_ld_gpr1;
   logic                       DEP_v_wb_ld_gpr2;
   logic                       DEP_v_wb_ld_gpr3;
   logic                       DEP_v_wb_ld_seg;
   logic                       DEP_v_wb_dcache_write;
   logic                       wb_repne_terminate_all;
   logic                       WB_stall;
   logic [wb_pkg::flags_w-1:0] flags_dataforwarded;
   logic [31:0]                count_dataforwarded;

   logic [31:0] pat_mem [0:mem_depth-1];
   int          num_vectors;
   logic        vectors_done;

   writeback uut (.*);

   initial begin
      CLK = 1'b0;
      forever begin
         #2 CLK = ~CLK;
      end
   end

   // marks entries the pattern file never wrote
   function automatic logic [31:0] fill_word(input int addr);
      return 32'h5eed_0000 ^ (addr * 32'h0001_0003);
   endfunction

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1, "run stopped on first error");
   endtask

   task automatic check_word(input string field, input logic [31:0] got,
                             input logic [31:0] expected);
      assert (got === expected) else begin
         stop_with_failure($sformatf("MISMATCH at %0d ns: %s is %h, expected %h",
                                     $time, field, got, expected));
      end
   endtask

   task automatic load_patterns();
      int fd;
      int last;
      for (int i = 0; i < mem_depth; i++) begin
         pat_mem[i] = fill_word(i);
      end
      fd = $fopen(pattern_file, "r");
      if (fd == 0) begin
         stop_with_failure("pattern file verif/writeback_patterns.txt could not be opened");
      end else begin
         $fclose(fd);
         $readmemh(pattern_file, pat_mem);
         if (pat_mem[0] == fill_word(0) || pat_mem[0] == 0 || pat_mem[0] > max_vectors) begin
            stop_with_failure("pattern file does not start with a valid vector count");
         end else begin
            num_vectors = int'(pat_mem[0]);
            last        = num_vectors * words_per_vec;
            if (pat_mem[last] == fill_word(last)) begin
               stop_with_failure($sformatf("pattern file holds fewer than %0d vectors",
                                           num_vectors));
            end
         end
      end
   endtask

   task automatic apply_vector(input int idx);
      int          base;
      logic [31:0] ctl_bits;
      base     = 1 + idx * words_per_vec;
      ctl_bits = pat_mem[base + 1];
      wb_ctrl               = pat_mem[base][15:0];
      WB_V                  = ctl_bits[0];
      WB_ex_ld_gpr1_wb      = ctl_bits[1];
      WB_ex_ld_gpr2_wb      = ctl_bits[2];
      WB_ex_dcache_write_wb = ctl_bits[3];
      WB_d2_repne_wb        = ctl_bits[4];
      In_write_ready        = ctl_bits[5];
      WB_NEIP               = pat_mem[base + 2];
      WB_NCS                = pat_mem[base + 3][15:0];
      WB_RESULT_A           = pat_mem[base + 4];
      WB_FLAGS              = pat_mem[base + 5];
      // pass-through fields tagged with the vector number
      WB_RESULT_B           = {16'hb000, 16'(idx)};
      WB_RESULT_C           = {16'hc000, 16'(idx)};
      WB_ADDRESS            = {16'had00, 16'(idx)};
      WB_DR1                = 3'(idx);
      WB_DR2                = 3'(idx + 1);
      WB_DR3                = 3'(idx + 2);
      WB_d2_datasize_all    = 2'(idx);
   endtask

   task automatic check_vector(input int idx);
      int          base;
      logic [31:0] exp_en;
      logic [31:0] exp_data1;
      base      = 1 + idx * words_per_vec + 6;
      exp_en    = pat_mem[base];
      exp_data1 = pat_mem[base + 1];
      check_word("WB_Final_ld_gpr1", 32'(WB_Final_ld_gpr1), 32'(exp_en[0]));
      check_word("WB_Final_ld_gpr2", 32'(WB_Final_ld_gpr2), 32'(exp_en[1]));
      check_word("WB_Final_ld_gpr3", 32'(WB_Final_ld_gpr3), 32'(exp_en[2]));
      check_word("WB_Final_ld_seg", 32'(WB_Final_ld_seg), 32'(exp_en[3]));
      check_word("WB_Final_ld_cs", 32'(WB_Final_ld_cs), 32'(exp_en[4]));
      check_word("WB_Final_ld_flags", 32'(WB_Final_ld_flags), 32'(exp_en[5]));
      check_word("WB_Final_ld_eip", 32'(WB_Final_ld_eip), 32'(exp_en[6]));
      check_word("DEP_v_wb_dcache_write", 32'(DEP_v_wb_dcache_write), 32'(exp_en[7]));
      check_word("wb_repne_terminate_all", 32'(wb_repne_terminate_all), 32'(exp_en[8]));
      check_word("WB_stall", 32'(WB_stall), 32'(exp_en[9]));
      check_word("DEP_v_wb_ld_gpr1", 32'(DEP_v_wb_ld_gpr1), 32'(exp_en[0]));
      check_word("DEP_v_wb_ld_gpr2", 32'(DEP_v_wb_ld_gpr2), 32'(exp_en[1]));
      check_word("DEP_v_wb_ld_gpr3", 32'(DEP_v_wb_ld_gpr3), 32'(exp_en[2]));
      check_word("DEP_v_wb_ld_seg", 32'(DEP_v_wb_ld_seg), 32'(exp_en[3]));
      check_word("WB_Final_data1", WB_Final_data1, exp_data1);
      check_word("WB_Final_EIP", WB_Final_EIP, pat_mem[base + 2]);
      check_word("WB_Final_CS", {16'b0, WB_Final_CS}, {16'b0, pat_mem[base + 3][15:0]});
      check_word("count_dataforwarded", count_dataforwarded, pat_mem[base + 4]);
      check_word("flags_dataforwarded", flags_dataforwarded, pat_mem[base + 5]);
      check_word("WB_Final_Flags", WB_Final_Flags, pat_mem[base + 5]);
      check_word("WB_Final_Dcache_Data low", WB_Final_Dcache_Data[31:0], exp_data1);
      check_word("WB_Final_Dcache_Data high", WB_Final_Dcache_Data[63:32], 32'h0);
      check_word("WB_Final_Dcache_address", WB_Final_Dcache_address, {16'had00, 16'(idx)});
      check_word("WB_Final_data2", WB_Final_data2, {16'hb000, 16'(idx)});
      check_word("WB_Final_data3", WB_Final_data3, {16'hc000, 16'(idx)});
      check_word("WB_Final_DR1..3", {23'b0, WB_Final_DR3, WB_Final_DR2, WB_Final_DR1},
                 {23'b0, 3'(idx + 2), 3'(idx + 1), 3'(idx)});
      check_word("WB_Final_datasize", {30'b0, WB_Final_datasize}, {30'b0, 2'(idx)});
   endtask

   // apply 1 ns after the edge, compare 1 ns before the next one
   task automatic run_vectors();
      for (int i = 0; i < num_vectors; i++) begin
         @(posedge CLK);
         #1;
         apply_vector(i);
         #2;
         check_vector(i);
      end
      vectors_done = 1'b1;
   endtask

   initial begin
      int cycles;
      vectors_done          = 1'b0;
      num_vectors           = 0;
      rst_n                 = 1'b0;
      WB_V                  = 1'b0;
      WB_NEIP               = '0;
      WB_NCS                = '0;
      wb_ctrl               = '0;
      WB_d2_datasize_all    = '0;
      WB_ex_ld_gpr1_wb      = 1'b0;
      WB_ex_ld_gpr2_wb      = 1'b0;
      WB_ex_dcache_write_wb = 1'b0;
      WB_d2_repne_wb        = 1'b0;
      WB_RESULT_A           = '0;
      WB_RESULT_B           = '0;
      WB_RESULT_C           = '0;
      WB_FLAGS              = '0;
      WB_DR1                = '0;
      WB_DR2                = '0;
      WB_DR3                = '0;
      WB_ADDRESS            = '0;
      In_write_ready        = 1'b1;
      load_patterns();
      repeat (4) @(posedge CLK);
      #1;
      rst_n = 1'b1;
      fork
         run_vectors();
      join_none
      cycles = 0;
      while (!vectors_done && cycles < timeout_cycles) begin
         @(posedge CLK);
         cycles++;
      end
      if (!vectors_done) begin
         stop_with_failure($sformatf("timeout: patterns not finished after %0d cycles",
                                     timeout_cycles));
      end else begin
         $display("Simulation passed");
         $finish;
      end
   end

endmodule

//--- verif/writeback_patterns.txt
// first entry: vector count; then per line, inputs then expected outputs
// in:  ctrl bits(0 V,1 gpr1,2 gpr2,3 dwr,4 repne,5 ready) neip ncs result_a wb_flags
// out: en(0 gpr1,1 gpr2,2 gpr3,3 seg,4 cs,5 flags,6 eip,7 dwr,8 term,9 stall)
//      data1 eip cs count flags
00000012
7fff 1e 00001000 0008 deadbeef ffffffff   000 00001000 00000000 0000 00000000 00000002
6000 01 00001004 0008 00000041 00000000   020 00000041 00001004 0008 00000000 00000002
02c0 05 00001008 0008 11111111 00000000   002 11111111 00001008 0008 00000000 00000043
2140 01 0000100c 0008 22222222 ffffff3e   020 22222222 0000100c 0008 00000000 00000043
02c0 05 00001010 0008 33333333 00000000   040 33333333 00001010 0008 00000000 00000816
1d40 03 00001014 0008 44444444 00000000   05d 44444444 00001014 0008 00000000 00000816
6000 01 00001018 0008 00000400 00000000   020 00000400 00001018 0008 00000000 00000816
2002 01 0000101c 0008 55555555 00000001   020 00000402 0000101c 0008 00000000 00000402
0203 05 00001020 0008 66666666 00000000   002 00001020 00001020 0008 00000000 00000403
0004 01 00001024 0008 00ab00f0 00000000   000 00ab00f0 00001024 0008 00000000 00000403
0078 11 00001028 0008 77777777 00000000   040 00ab00f0 00ab00f0 00f0 00ab00f0 00000403
000a 01 0000102c 0008 88888888 00000000   000 00000403 0000102c 0008 00ab00f0 00000403
2000 01 00001030 0008 99999999 00000040   020 99999999 00001030 0008 00ab00f0 00000403
0008 11 00001034 0008 aaaaaaaa 00000000   100 00ab00f0 00001034 0008 00ab00f0 00000442
2004 09 00001038 0008 bbbbbbbb 00000000   2a0 bbbbbbbb 00001038 0008 00ab00f0 00000442
2004 09 00001038 0008 bbbbbbbb 00000000   2a0 bbbbbbbb 00001038 0008 00ab00f0 00000442
2004 29 00001038 0008 bbbbbbbb 00000000   0a0 bbbbbbbb 00001038 0008 00ab00f0 00000442
0000 20 0000103c 0008 00000000 00000000   000 00000000 0000103c 0008 bbbbbbbb 00000402

//--- writeback.f
logic/wb_pkg.sv
logic/wb_flags_reg.sv
logic/wb_branch_cond.sv
logic/wb_commit_gate.sv
logic/wb_operand_select.sv
logic/writeback.sv
verif/writeback_assertions.sv
verif/writeback_tb.sv

//--- Makefile
# Verilator build for the writeback stage testbench

VERILATOR ?= verilator
TOP       ?= writeback_tb
FILELIST  ?= writeback.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= Simulation passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
